// ==== dv/led_driver_tb.sv ====
`timescale 1ns/1ps

module led_driver_tb;
   import led_drv_cfg_pkg::*;
   import led_drv_proto_pkg::*;

   // what a table step does to the DUT.
   typedef enum logic [1:0] {
      OP_WRITE,
      OP_SYNC,
      OP_LOD,
      OP_WAIT
   } op_e;

   // pulse pattern a step must produce.
   typedef enum logic [1:0] {
      EXP_NONE,
      EXP_CFG,
      EXP_LINE,
      EXP_LOD
   } exp_e;

   typedef struct packed {
      op_e                   op;
      logic [CFG_ADDR_W-1:0] addr;
      logic [CFG_DATA_W-1:0] data;
      logic [N_DRIVERS-1:0]  mask;
      logic [9:0]            resync;
      exp_e                  exp_kind;
      drv_state_e            state;
   } step_t;

   logic                  clk_33;
   logic                  nrst;
   logic                  cfg_wr;
   logic [CFG_ADDR_W-1:0] cfg_addr;
   logic [CFG_DATA_W-1:0] cfg_wdata;
   logic                  framebuffer_sync;
   logic                  framebuffer_rd;
   logic [N_DRIVERS-1:0]  framebuffer_dat;
   logic                  driver_sclk;
   logic                  driver_gclk;
   logic                  driver_lat;
   logic [N_DRIVERS-1:0]  drivers_sin;
   logic                  driver_sout;
   logic [SOUT_MUX_W-1:0] driver_sout_mux;
   logic [N_DRIVERS-1:0]  lod_fault;
   drv_state_e            drv_state;

   step_t                steps[$];
   logic                 table_ready = 1'b0;
   logic [FC_BITS-1:0]   fc_model;
   logic [N_DRIVERS-1:0] fault_mask;
   logic [31:0]          lcg_state;
   logic                 rd_pend;
   logic [N_DRIVERS-1:0] fb_words[$];
   logic [N_DRIVERS-1:0] sin_log[$];
   logic                 lat_log[$];
   int                   pulse_cnt = 0;
   int                   gclk_cnt = 0;
   int                   rd_cnt = 0;

   always #4 clk_33 = ~clk_33;

   led_driver_top i_dut (
      .clk_33           (clk_33),
      .nrst             (nrst),
      .cfg_wr           (cfg_wr),
      .cfg_addr         (cfg_addr),
      .cfg_wdata        (cfg_wdata),
      .framebuffer_sync (framebuffer_sync),
      .framebuffer_rd   (framebuffer_rd),
      .framebuffer_dat  (framebuffer_dat),
      .driver_sclk      (driver_sclk),
      .driver_gclk      (driver_gclk),
      .driver_lat       (driver_lat),
      .drivers_sin      (drivers_sin),
      .driver_sout      (driver_sout),
      .driver_sout_mux  (driver_sout_mux),
      .lod_fault        (lod_fault),
      .drv_state        (drv_state)
   );

   // ******************************
   // models and monitors
   // ******************************

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   // read request seen in the middle of the cycle, where it is stable.
   always @(negedge clk_33) begin
      rd_pend = framebuffer_rd;
   end

   // framebuffer answers in the next cycle with a fresh pseudo random word.
   always @(posedge clk_33) begin
      #1;
      if (rd_pend) begin
         lcg_state = lcg_next(lcg_state);
         framebuffer_dat = lcg_state[31:2];
         fb_words.push_back(lcg_state[31:2]);
         rd_cnt++;
      end
   end

   // open led on every driver whose bit is set in the mask.
   always @(posedge clk_33) begin
      #1;
      driver_sout = fault_mask[driver_sout_mux];
   end

   // the driver chain takes data and lat on the rising sclk edge.
   always @(posedge driver_sclk) begin
      sin_log.push_back(drivers_sin);
      lat_log.push_back(driver_lat);
      pulse_cnt++;
   end

   always @(posedge driver_gclk) begin
      gclk_cnt++;
   end

   // run time grows with the table.
   initial begin
      wait (table_ready);
      repeat (steps.size() * 2000) @(posedge clk_33);
      $display("Watchdog expired before all table steps finished");
      $display("Result: FAILED");
      $fatal(1, "watchdog");
   end

   // ******************************
   // helpers
   // ******************************

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] want);
      if (got !== want) begin
         $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, want);
         $display("Result: FAILED");
         $fatal(1, "check");
      end
   endtask

   task automatic check_reset_outputs();
      check_value("driver_lat", 64'(driver_lat), 64'(0));
      check_value("framebuffer_rd", 64'(framebuffer_rd), 64'(0));
      check_value("drivers_sin", 64'(drivers_sin), 64'(0));
      check_value("driver_sout_mux", 64'(driver_sout_mux), 64'(0));
      check_value("lod_fault", 64'(lod_fault), 64'(0));
      check_value("drv_state", 64'(drv_state), 64'(STALL));
   endtask

   task automatic bus_write(input logic [CFG_ADDR_W-1:0] a, input logic [CFG_DATA_W-1:0] d);
      @(posedge clk_33);
      #1;
      cfg_wr    = 1'b1;
      cfg_addr  = a;
      cfg_wdata = d;
      @(posedge clk_33);
      #1;
      cfg_wr = 1'b0;
   endtask

   task automatic sync_pulse();
      @(posedge clk_33);
      #1;
      framebuffer_sync = 1'b1;
      @(posedge clk_33);
      #1;
      framebuffer_sync = 1'b0;
   endtask

   function automatic int pulse_total(input exp_e e);
      case (e)
         EXP_CFG:  return LAT_FCWRTEN + FC_BITS;
         EXP_LINE: return GS_BITS * GS_WORDS;
         EXP_LOD:  return N_DRIVERS * LOD_BITS;
         default:  return 0;
      endcase
   endfunction

   task automatic add_step(input op_e op, input logic [CFG_ADDR_W-1:0] addr,
                           input logic [CFG_DATA_W-1:0] data,
                           input logic [N_DRIVERS-1:0] mask, input logic [9:0] resync,
                           input exp_e kind, input drv_state_e state);
      step_t s;
      s.op       = op;
      s.addr     = addr;
      s.data     = data;
      s.mask     = mask;
      s.resync   = resync;
      s.exp_kind = kind;
      s.state    = state;
      steps.push_back(s);
   endtask

   // ******************************
   // step execution
   // ******************************

   task automatic run_step(input step_t s);
      int                   base;
      int                   gclk_base;
      int                   rd_base;
      int                   target;
      int                   k;
      int                   j;
      logic [N_DRIVERS-1:0] want_sin;
      logic                 want_lat;
      base      = pulse_cnt;
      gclk_base = gclk_cnt;
      rd_base   = rd_cnt;
      target    = pulse_total(s.exp_kind);
      case (s.op)
         OP_WRITE: begin
            // the model keeps its own copy of the fc slices.
            if (s.addr != REG_CTRL) begin
               fc_model[s.addr * CFG_DATA_W +: CFG_DATA_W] = s.data;
            end
            bus_write(s.addr, s.data);
         end
         OP_SYNC: begin
            sync_pulse();
            // optional second sync, meant to land inside the line.
            if (s.resync != 0) begin
               repeat (s.resync) @(posedge clk_33);
               sync_pulse();
            end
         end
         OP_LOD: begin
            fault_mask = s.mask;
            bus_write(REG_CTRL, s.data);
         end
         default: begin
            // nothing driven.
         end
      endcase
      // pulses land on the falling clk_33 edge, state moves on the rising one.
      while (pulse_cnt < base + target) @(posedge clk_33);
      while (drv_state != s.state) @(negedge clk_33);
      // every step ends with a whole line of quiet so a late or extra job shows up.
      repeat (GCLK_LINE + 16) @(negedge clk_33);
      check_value("sclk_pulses", 64'(pulse_cnt - base), 64'(target));
      check_value("framebuffer_reads", 64'(rd_cnt - rd_base),
                  64'((s.exp_kind == EXP_LINE) ? target : 0));
      check_value("drv_state", 64'(drv_state), 64'(s.state));
      check_value("driver_gclk_running", 64'(gclk_cnt != gclk_base), 64'(s.state != STALL));
      for (k = 0; k < target; k++) begin
         j = k - LAT_FCWRTEN;
         case (s.exp_kind)
            EXP_CFG: begin
               // fcwrten with zero data, then the fc word msb first on every line.
               if (k < LAT_FCWRTEN) begin
                  want_sin = '0;
                  want_lat = 1'b1;
               end else begin
                  want_sin = fc_model[FC_BITS - 1 - j] ? '1 : '0;
                  want_lat = (j >= FC_BITS - LAT_WRTFC);
               end
            end
            EXP_LINE: begin
               // wrtgs on the last bit of a word, latgs on the last 3 of word 48.
               want_sin = fb_words.pop_front();
               if (k / GS_BITS == GS_WORDS - 1) begin
                  want_lat = (k % GS_BITS >= GS_BITS - LAT_LATGS);
               end else begin
                  want_lat = (k % GS_BITS == GS_BITS - 1);
               end
            end
            default: begin
               want_sin = '0;
               want_lat = 1'b0;
            end
         endcase
         check_value($sformatf("drivers_sin[pulse %0d]", k), 64'(sin_log.pop_front()),
                     64'(want_sin));
         check_value($sformatf("driver_lat[pulse %0d]", k), 64'(lat_log.pop_front()),
                     64'(want_lat));
      end
      if (s.exp_kind == EXP_LOD) begin
         check_value("lod_fault", 64'(lod_fault), 64'(s.mask));
         // select wraps back to the first driver after the scan.
         check_value("driver_sout_mux", 64'(driver_sout_mux), 64'(0));
      end
   endtask

   task automatic build_table();
      // stall: no clocks, syncs ignored.
      add_step(OP_WAIT, '0, '0, '0, '0, EXP_NONE, STALL);
      add_step(OP_SYNC, '0, '0, '0, '0, EXP_NONE, STALL);
      // fc word, then configuration.
      add_step(OP_WRITE, REG_FC0, 16'ha5c3, '0, '0, EXP_NONE, STALL);
      add_step(OP_WRITE, REG_FC1, 16'h1e69, '0, '0, EXP_NONE, STALL);
      add_step(OP_WRITE, REG_FC2, 16'h8b27, '0, '0, EXP_NONE, STALL);
      add_step(OP_WRITE, REG_CTRL, 16'h0001, '0, '0, EXP_CFG, STREAM);
      // stream enable still clear.
      add_step(OP_SYNC, '0, '0, '0, '0, EXP_NONE, STREAM);
      add_step(OP_WRITE, REG_CTRL, 16'h0002, '0, '0, EXP_NONE, STREAM);
      add_step(OP_SYNC, '0, '0, '0, '0, EXP_LINE, STREAM);
      add_step(OP_SYNC, '0, '0, '0, 10'd200, EXP_LINE, STREAM);
      // two lod scans with different masks, stream enable kept set.
      add_step(OP_LOD, REG_CTRL, 16'h0006, 30'h2000_0801, '0, EXP_LOD, STREAM);
      add_step(OP_LOD, REG_CTRL, 16'h0006, 30'h0f0f_3006, '0, EXP_LOD, STREAM);
      add_step(OP_SYNC, '0, '0, '0, '0, EXP_LINE, STREAM);
      // reconfigure from stream, which also drops stream enable.
      add_step(OP_WRITE, REG_FC0, 16'h3cf1, '0, '0, EXP_NONE, STREAM);
      add_step(OP_WRITE, REG_CTRL, 16'h0001, '0, '0, EXP_CFG, STREAM);
      add_step(OP_SYNC, '0, '0, '0, '0, EXP_NONE, STREAM);
   endtask

   // ******************************
   // main sequence
   // ******************************

   initial begin
      clk_33           = 1'b0;
      nrst             = 1'b0;
      cfg_wr           = 1'b0;
      cfg_addr         = '0;
      cfg_wdata        = '0;
      framebuffer_sync = 1'b0;
      framebuffer_dat  = '0;
      driver_sout      = 1'b0;
      fault_mask       = '0;
      fc_model         = '0;
      lcg_state        = 32'd55876;
      rd_pend          = 1'b0;
      build_table();
      table_ready = 1'b1;
      // outputs quiet during reset and right after it.
      repeat (10) begin
         @(negedge clk_33);
         check_reset_outputs();
      end
      @(posedge clk_33);
      #1;
      nrst = 1'b1;
      repeat (4) begin
         @(negedge clk_33);
         check_reset_outputs();
      end
      check_value("sclk_pulses", 64'(pulse_cnt), 64'(0));
      check_value("gclk_edges", 64'(gclk_cnt), 64'(0));
      foreach (steps[i]) begin
         run_step(steps[i]);
      end
      $display("Result: PASSED");
      $finish;
   end

endmodule

// ==== filelist.f ====
hw/led_drv_cfg_pkg.sv
hw/led_drv_proto_pkg.sv
hw/drv_cfg_if.sv
hw/shift_job_if.sv
hw/drv_cfg_regs.sv
hw/driver_main_controller.sv
hw/sin_shift_engine.sv
hw/lod_scanner.sv
hw/led_driver_top.sv
dv/led_driver_tb.sv

// ==== hw/driver_main_controller.sv ====
`timescale 1ns/1ps

module driver_main_controller (
   input  logic        clk_33,
   input  logic        nrst,
   input  logic        framebuffer_sync,
   drv_cfg_if.ctrl     cfg,
   shift_job_if.ctrl   job,
   input  logic        lod_done,
   output logic        driver_gclk
);
   import led_drv_proto_pkg::*;

   logic fc_phase;
   logic eng_idle;
   logic gclk_en;

   // engine free and no job already on its way.
   assign eng_idle = !job.job_busy && !job.job_start;

   // ******************************
   // state machine
   // ******************************

   // fc_phase low while FCWRTEN runs, high while WRTFC runs.
   always_ff @(posedge clk_33 or negedge nrst) begin
      if (!nrst) begin
         cfg.state     <= STALL;
         job.job_start <= 1'b0;
         job.job_kind  <= JOB_FCWRTEN;
         fc_phase      <= 1'b0;
      end else begin
         // start is a strobe.
         job.job_start <= 1'b0;
         case (cfg.state)
            STALL: begin
               // drivers unconfigured, wait for the host.
               if (cfg.cfg_req) begin
                  cfg.state     <= CONFIG;
                  job.job_start <= 1'b1;
                  job.job_kind  <= JOB_FCWRTEN;
                  fc_phase      <= 1'b0;
               end
            end
            CONFIG: begin
               // FCWRTEN then WRTFC, back to back.
               if (job.job_done) begin
                  if (!fc_phase) begin
                     job.job_start <= 1'b1;
                     job.job_kind  <= JOB_WRTFC;
                     fc_phase      <= 1'b1;
                  end else begin
                     cfg.state <= STREAM;
                  end
               end
            end
            STREAM: begin
               // requests are only taken between lines.
               // priority is reconfigure, then lod, then a new line.
               if (eng_idle) begin
                  if (cfg.cfg_req) begin
                     cfg.state     <= CONFIG;
                     job.job_start <= 1'b1;
                     job.job_kind  <= JOB_FCWRTEN;
                     fc_phase      <= 1'b0;
                  end else if (cfg.lod_req) begin
                     cfg.state     <= LOD;
                     job.job_start <= 1'b1;
                     job.job_kind  <= JOB_LOD_READ;
                  end else if (framebuffer_sync && cfg.stream_en) begin
                     job.job_start <= 1'b1;
                     job.job_kind  <= JOB_GS_LINE;
                  end
               end
            end
            default: begin
               // lod: one read job per driver until the scanner wraps.
               if (lod_done) begin
                  cfg.state <= STREAM;
               end else if (job.job_done) begin
                  job.job_start <= 1'b1;
                  job.job_kind  <= JOB_LOD_READ;
               end
            end
         endcase
      end
   end

   // ******************************
   // gclk gating
   // ******************************

   // enable moves on the falling edge while clk_33 is low.
   // the and gate below then never sees a partial pulse.
   always_ff @(negedge clk_33 or negedge nrst) begin
      if (!nrst) begin
         gclk_en <= 1'b0;
      end else begin
         gclk_en <= (cfg.state == STREAM) || (cfg.state == LOD);
      end
   end

   assign driver_gclk = clk_33 & gclk_en;

endmodule

// ==== hw/drv_cfg_if.sv ====
`timescale 1ns/1ps

interface drv_cfg_if;
   import led_drv_cfg_pkg::*;
   import led_drv_proto_pkg::*;

   // settings from the register block.
   logic [FC_BITS-1:0]   fc_word;
   logic                 stream_en;

   // one-cycle requests.
   // dropped by the controller when it is not ready.
   logic                 cfg_req;
   logic                 lod_req;

   // status back towards the host side.
   logic [N_DRIVERS-1:0] lod_fault;
   drv_state_e           state;

   // register block side.
   modport regs (
      output fc_word,
      output stream_en,
      output cfg_req,
      output lod_req
   );

   // controller side, shared with the scanner which only drives lod_fault.
   modport ctrl (
      input  fc_word,
      input  stream_en,
      input  cfg_req,
      input  lod_req,
      output lod_fault,
      output state
   );

endinterface

// ==== hw/drv_cfg_regs.sv ====
`timescale 1ns/1ps

module drv_cfg_regs (
   input  logic                                  clk_33,
   input  logic                                  nrst,
   input  logic                                  cfg_wr,
   input  logic [led_drv_cfg_pkg::CFG_ADDR_W-1:0] cfg_addr,
   input  logic [led_drv_cfg_pkg::CFG_DATA_W-1:0] cfg_wdata,
   drv_cfg_if.regs                               cfg
);
   import led_drv_cfg_pkg::*;

   logic ctrl_wr;

   // write to the control register in this cycle.
   assign ctrl_wr = cfg_wr && (cfg_addr == REG_CTRL);

   // ******************************
   // function-control word
   // ******************************

   // three slices, low slice at REG_FC0.
   always_ff @(posedge clk_33) begin
      if (cfg_wr) begin
         case (cfg_addr)
            REG_FC0: cfg.fc_word[0*CFG_DATA_W +: CFG_DATA_W] <= cfg_wdata;
            REG_FC1: cfg.fc_word[1*CFG_DATA_W +: CFG_DATA_W] <= cfg_wdata;
            REG_FC2: cfg.fc_word[2*CFG_DATA_W +: CFG_DATA_W] <= cfg_wdata;
            default: ;
         endcase
      end
   end

   // ******************************
   // control register
   // ******************************

   always_ff @(posedge clk_33 or negedge nrst) begin
      if (!nrst) begin
         cfg.stream_en <= 1'b0;
         cfg.cfg_req   <= 1'b0;
         cfg.lod_req   <= 1'b0;
      end else begin
         // stream enable is the only stored bit.
         if (ctrl_wr) begin
            cfg.stream_en <= cfg_wdata[CTRL_STREAM_EN];
         end
         // start bits become one-cycle strobes, one cycle after the write.
         cfg.cfg_req <= ctrl_wr && cfg_wdata[CTRL_CFG_START];
         cfg.lod_req <= ctrl_wr && cfg_wdata[CTRL_LOD_START];
      end
   end

endmodule

// ==== hw/led_driver_top.sv ====
`timescale 1ns/1ps

module led_driver_top (
   input  logic                                    clk_33,
   input  logic                                    nrst,
   // host register bus.
   input  logic                                    cfg_wr,
   input  logic [led_drv_cfg_pkg::CFG_ADDR_W-1:0]  cfg_addr,
   input  logic [led_drv_cfg_pkg::CFG_DATA_W-1:0]  cfg_wdata,
   // external framebuffer, answers a read in the next cycle.
   input  logic                                    framebuffer_sync,
   output logic                                    framebuffer_rd,
   input  logic [led_drv_proto_pkg::N_DRIVERS-1:0] framebuffer_dat,
   // driver chain lines.
   output logic                                    driver_sclk,
   output logic                                    driver_gclk,
   output logic                                    driver_lat,
   output logic [led_drv_proto_pkg::N_DRIVERS-1:0] drivers_sin,
   input  logic                                    driver_sout,
   output logic [led_drv_proto_pkg::SOUT_MUX_W-1:0] driver_sout_mux,
   // status.
   output logic [led_drv_proto_pkg::N_DRIVERS-1:0] lod_fault,
   output led_drv_proto_pkg::drv_state_e           drv_state
);

   logic lod_done;

   drv_cfg_if   cfg_bus ();
   shift_job_if job_bus ();

   drv_cfg_regs i_regs (
      .clk_33    (clk_33),
      .nrst      (nrst),
      .cfg_wr    (cfg_wr),
      .cfg_addr  (cfg_addr),
      .cfg_wdata (cfg_wdata),
      .cfg       (cfg_bus)
   );

   driver_main_controller i_ctrl (
      .clk_33           (clk_33),
      .nrst             (nrst),
      .framebuffer_sync (framebuffer_sync),
      .cfg              (cfg_bus),
      .job              (job_bus),
      .lod_done         (lod_done),
      .driver_gclk      (driver_gclk)
   );

   sin_shift_engine i_engine (
      .clk_33          (clk_33),
      .nrst            (nrst),
      .job             (job_bus),
      .fc_word         (cfg_bus.fc_word),
      .framebuffer_dat (framebuffer_dat),
      .framebuffer_rd  (framebuffer_rd),
      .driver_sclk     (driver_sclk),
      .driver_lat      (driver_lat),
      .drivers_sin     (drivers_sin)
   );

   lod_scanner i_scanner (
      .clk_33          (clk_33),
      .nrst            (nrst),
      .cfg             (cfg_bus),
      .job             (job_bus),
      .driver_sout     (driver_sout),
      .driver_sout_mux (driver_sout_mux),
      .lod_done        (lod_done)
   );

   // status straight from the shared bundle.
   assign lod_fault = cfg_bus.lod_fault;
   assign drv_state = cfg_bus.state;

endmodule

// ==== hw/led_drv_cfg_pkg.sv ====
package led_drv_cfg_pkg;

   // ******************************
   // host register bus
   // ******************************

   // address and data widths.
   localparam int CFG_ADDR_W = 2;
   localparam int CFG_DATA_W = 16;

   // width of the driver function-control word.
   // three bus words, low slice first.
   localparam int FC_BITS = 48;

   // register map.
   localparam logic [CFG_ADDR_W-1:0] REG_FC0  = 2'd0;
   localparam logic [CFG_ADDR_W-1:0] REG_FC1  = 2'd1;
   localparam logic [CFG_ADDR_W-1:0] REG_FC2  = 2'd2;
   localparam logic [CFG_ADDR_W-1:0] REG_CTRL = 2'd3;

   // REG_CTRL bit positions.
   // the two start bits are strobes and read back nothing.
   localparam int CTRL_CFG_START = 0;
   localparam int CTRL_STREAM_EN = 1;
   localparam int CTRL_LOD_START = 2;

endpackage

// ==== hw/led_drv_proto_pkg.sv ====
package led_drv_proto_pkg;

   // ******************************
   // panel and line geometry
   // ******************************

   // one serial data chain per driver position.
   localparam int N_DRIVERS  = 30;
   localparam int SOUT_MUX_W = 5;

   // grayscale words are 9 bits, 48 of them per line (16 leds x rgb).
   localparam int GS_BITS  = 9;
   localparam int GS_WORDS = 48;

   // a line spans 512 gclk cycles.
   // the time not used for shifting is spent blanking at the front.
   localparam int GCLK_LINE    = 512;
   localparam int BLANK_CYCLES = GCLK_LINE - GS_BITS * GS_WORDS;

   // ******************************
   // lat commands
   // ******************************

   // number of sclk edges with lat high that select each command.
   localparam int LAT_FCWRTEN = 15;
   localparam int LAT_WRTFC   = 5;
   localparam int LAT_WRTGS   = 1;
   localparam int LAT_LATGS   = 3;

   // sout bits shifted out of one driver during open detection.
   localparam int LOD_BITS = 48;

   // controller states.
   typedef enum logic [1:0] {
      STALL,
      CONFIG,
      STREAM,
      LOD
   } drv_state_e;

   // kinds of work handed to the shift engine.
   typedef enum logic [1:0] {
      JOB_FCWRTEN,
      JOB_WRTFC,
      JOB_GS_LINE,
      JOB_LOD_READ
   } shift_job_e;

endpackage

// ==== hw/lod_scanner.sv ====
`timescale 1ns/1ps

module lod_scanner (
   input  logic                                   clk_33,
   input  logic                                   nrst,
   drv_cfg_if.ctrl                                cfg,
   shift_job_if.mon                               job,
   input  logic                                   driver_sout,
   output logic [led_drv_proto_pkg::SOUT_MUX_W-1:0] driver_sout_mux,
   output logic                                   lod_done
);
   import led_drv_proto_pkg::*;

   logic lod_job;
   logic last_drv;

   assign lod_job  = (job.job_kind == JOB_LOD_READ);
   assign last_drv = (driver_sout_mux == SOUT_MUX_W'(N_DRIVERS - 1));

   // scan complete when the read of the last driver finishes.
   // combinational so the controller issues no extra read.
   assign lod_done = job.job_done && lod_job && last_drv;

   // ******************************
   // sout sampling
   // ******************************

   always_ff @(posedge clk_33 or negedge nrst) begin
      if (!nrst) begin
         driver_sout_mux <= '0;
         cfg.lod_fault   <= '0;
      end else begin
         // a read starting on driver 0 opens a new scan.
         if (job.job_start && lod_job && (driver_sout_mux == '0)) begin
            cfg.lod_fault <= '0;
         end else if (job.bit_strobe && lod_job && driver_sout) begin
            // any high sout bit flags the selected driver.
            cfg.lod_fault[driver_sout_mux] <= 1'b1;
         end
         // next driver after each read, wrap after the last one.
         if (job.job_done && lod_job) begin
            driver_sout_mux <= last_drv ? '0 : driver_sout_mux + 1'b1;
         end
      end
   end

endmodule

// ==== hw/shift_job_if.sv ====
`timescale 1ns/1ps

interface shift_job_if;
   import led_drv_proto_pkg::*;

   // job request, only raised while the engine is idle.
   logic       job_start;
   shift_job_e job_kind;

   // engine progress.
   // bit_strobe marks every cycle that carries an sclk pulse.
   logic       bit_strobe;
   logic       job_busy;
   logic       job_done;

   modport ctrl (
      output job_start,
      output job_kind,
      input  job_busy,
      input  job_done
   );

   modport eng (
      input  job_start,
      input  job_kind,
      output bit_strobe,
      output job_busy,
      output job_done
   );

   // passive view for the lod scanner.
   modport mon (
      input job_start,
      input job_kind,
      input bit_strobe,
      input job_done
   );

endinterface

// ==== hw/sin_shift_engine.sv ====
`timescale 1ns/1ps

module sin_shift_engine (
   input  logic                                  clk_33,
   input  logic                                  nrst,
   shift_job_if.eng                              job,
   input  logic [led_drv_cfg_pkg::FC_BITS-1:0]   fc_word,
   input  logic [led_drv_proto_pkg::N_DRIVERS-1:0] framebuffer_dat,
   output logic                                  framebuffer_rd,
   output logic                                  driver_sclk,
   output logic                                  driver_lat,
   output logic [led_drv_proto_pkg::N_DRIVERS-1:0] drivers_sin
);
   import led_drv_cfg_pkg::*;
   import led_drv_proto_pkg::*;

   shift_job_e kind;
   logic       in_blank;
   logic       sclk_en;
   logic       done;
   logic [6:0] blank_cnt;
   logic [5:0] bit_cnt;
   logic [5:0] word_cnt;
   logic       busy;
   logic       last_blank;
   logic       last_bit;
   logic       last_pulse;
   logic       lat_win;

   // counters describe the current cycle.
   // bit_cnt is the pulse index, or the bit inside the word for gs lines.
   assign busy       = in_blank | sclk_en | done;
   assign last_blank = (blank_cnt == 7'(BLANK_CYCLES - 1));
   assign last_bit   = (bit_cnt == 6'(GS_BITS - 1));

   always_comb begin
      case (kind)
         JOB_FCWRTEN: last_pulse = (bit_cnt == 6'(LAT_FCWRTEN - 1));
         JOB_WRTFC:   last_pulse = (bit_cnt == 6'(FC_BITS - 1));
         JOB_GS_LINE: last_pulse = last_bit && (word_cnt == 6'(GS_WORDS - 1));
         default:     last_pulse = (bit_cnt == 6'(LOD_BITS - 1));
      endcase
   end

   // ******************************
   // job sequencing
   // ******************************

   always_ff @(posedge clk_33 or negedge nrst) begin
      if (!nrst) begin
         kind      <= JOB_FCWRTEN;
         in_blank  <= 1'b0;
         sclk_en   <= 1'b0;
         done      <= 1'b0;
         blank_cnt <= '0;
         bit_cnt   <= '0;
         word_cnt  <= '0;
      end else begin
         done <= 1'b0;
         if (job.job_start && !busy) begin
            // gs lines open with blanking, all other jobs pulse at once.
            kind      <= job.job_kind;
            blank_cnt <= '0;
            bit_cnt   <= '0;
            word_cnt  <= '0;
            in_blank  <= (job.job_kind == JOB_GS_LINE);
            sclk_en   <= (job.job_kind != JOB_GS_LINE);
         end else if (in_blank) begin
            if (last_blank) begin
               in_blank <= 1'b0;
               sclk_en  <= 1'b1;
            end else begin
               blank_cnt <= blank_cnt + 1'b1;
            end
         end else if (sclk_en) begin
            if (last_pulse) begin
               sclk_en <= 1'b0;
               done    <= 1'b1;
            end else if ((kind == JOB_GS_LINE) && last_bit) begin
               bit_cnt  <= '0;
               word_cnt <= word_cnt + 1'b1;
            end else begin
               bit_cnt <= bit_cnt + 1'b1;
            end
         end
      end
   end

   assign job.bit_strobe = sclk_en;
   assign job.job_busy   = busy;
   assign job.job_done   = done;

   // ******************************
   // driver lines
   // ******************************

   // sclk rises mid-cycle.
   // enable changes at the rising clk_33 edge while the inverted clock is low.
   assign driver_sclk = ~clk_33 & sclk_en;

   // lat window per command.
   // gs words end in WRTGS, the last word in LATGS.
   always_comb begin
      case (kind)
         JOB_FCWRTEN: lat_win = 1'b1;
         JOB_WRTFC:   lat_win = (bit_cnt >= 6'(FC_BITS - LAT_WRTFC));
         JOB_GS_LINE: begin
            if (word_cnt == 6'(GS_WORDS - 1)) begin
               lat_win = (bit_cnt >= 6'(GS_BITS - LAT_LATGS));
            end else begin
               lat_win = (bit_cnt >= 6'(GS_BITS - LAT_WRTGS));
            end
         end
         default:     lat_win = 1'b0;
      endcase
   end

   assign driver_lat = sclk_en & lat_win;

   // read one cycle ahead of every gs pulse.
   // the first read sits in the last blanking cycle.
   assign framebuffer_rd = (kind == JOB_GS_LINE) &&
                           ((in_blank && last_blank) || (sclk_en && !last_pulse));

   // data source per job.
   // fc word msb first, replicated on every chain.
   always_comb begin
      drivers_sin = '0;
      if (sclk_en) begin
         case (kind)
            JOB_WRTFC:   drivers_sin = {N_DRIVERS{fc_word[FC_BITS - 1 - bit_cnt]}};
            JOB_GS_LINE: drivers_sin = framebuffer_dat;
            default:     drivers_sin = '0;
         endcase
      end
   end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the led driver testbench with verilator, run it and look for the pass line.
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
   --top-module led_driver_tb -f filelist.f -o led_driver_sim &&
./obj_dir/led_driver_sim | tee /dev/stderr | grep "Result: PASSED" > /dev/null &&
echo "simulation passed" ||
{
   echo "simulation failed"
   exit 1
}
